// ==== rvviTracePkg.sv ====
/*
 * RVFI to RVVI trace converter shared definitions
 * Widths, CSR slot order, interrupt watch mask and the
 * packed records passed between the pipeline stages
 */
package rvviTracePkg;

    ////////////////////
    // Widths and counts
    ////////////////////
    localparam int XLEN         = 32;
    localparam int NUM_GPR      = 32;
    localparam int GPR_ADDR_W   = 5;
    localparam int NUM_RD_PORTS = 2;
    localparam int IRQ_W        = 32;

    // Fixed CSR slot order, replaces the CSR address
    typedef enum logic [2:0] {
        CSR_MSTATUS  = 3'd0,
        CSR_MIE      = 3'd1,
        CSR_MTVEC    = 3'd2,
        CSR_MSCRATCH = 3'd3,
        CSR_MEPC     = 3'd4,
        CSR_MCAUSE   = 3'd5
    } csrIdxE;

    // Last slot closes the list
    localparam int NUM_CSR = int'(CSR_MCAUSE) + 1;

    // Software (3), timer (7), external (11) and local 16..31
    localparam logic [IRQ_W-1:0] IRQ_WATCH_MASK = 32'hFFFF_0888;

    ////////////////////
    // Record types
    ////////////////////
    typedef struct packed {
        logic [XLEN-1:0] rdata;
        logic [XLEN-1:0] wdata;
        logic [XLEN-1:0] wmask;
    } csrAccessT;

    typedef struct packed {
        logic [GPR_ADDR_W-1:0] addr;
        logic [XLEN-1:0]       data;
    } rdWriteT;

    typedef struct packed {
        logic [63:0]     order;
        logic [XLEN-1:0] pc;
        logic [31:0]     insn;
        logic            trap;
        logic            intr;
        logic [1:0]      mode;
        logic [1:0]      ixl;
    } insnInfoT;

    // One retired instruction as seen on RVFI
    typedef struct packed {
        insnInfoT                         info;
        rdWriteT [NUM_RD_PORTS-1:0]       rd;
        csrAccessT [NUM_CSR-1:0]          csr;
    } rvfiRecordT;

    // After GPR expansion, CSR accesses still raw
    typedef struct packed {
        insnInfoT                         info;
        logic [NUM_GPR-1:0]               gprMask;
        logic [NUM_GPR-1:0][XLEN-1:0]     gprData;
        csrAccessT [NUM_CSR-1:0]          csr;
    } decodedT;

    // Finished RVVI record
    typedef struct packed {
        insnInfoT                         info;
        logic [NUM_GPR-1:0]               gprMask;
        logic [NUM_GPR-1:0][XLEN-1:0]     gprData;
        logic [NUM_CSR-1:0][XLEN-1:0]     csrValue;
        logic [NUM_CSR-1:0]               csrChanged;
    } rvviRecordT;

    typedef struct packed {
        logic [IRQ_W-1:0] level;
        logic [IRQ_W-1:0] changed;
    } netEventT;

endpackage

// ==== pipeStage.sv ====
/*
 * Generic one-entry valid/ready pipeline register
 * Payload type is set per instance
 */
`timescale 1ns/1ps

module pipeStage #(
    parameter type payloadT = logic
) (
    input  logic    rvvi,
    input  logic    arstN_i,
    input  logic    inValid_i,
    input  payloadT inData_i,
    output logic    inReady_o,
    output logic    outValid_o,
    output payloadT outData_o,
    input  logic    outReady_i
);

    logic    full;
    payloadT dataQ;

    // Accept when empty or when the held entry leaves this cycle
    assign inReady_o  = !full || outReady_i;
    assign outValid_o = full;
    assign outData_o  = dataQ;

    always_ff @(posedge rvvi or negedge arstN_i) begin
        if (!arstN_i) begin
            full <= 1'b0;
        end else if (inReady_o) begin
            full <= inValid_i;
        end
    end

    always_ff @(posedge rvvi) begin
        if (inValid_i && inReady_o) begin
            dataQ <= inData_i;
        end
    end

    ////////////////////
    // Handshake checks
    ////////////////////
    holdValid: assert property (@(posedge rvvi) disable iff (!arstN_i)
        outValid_o && !outReady_i |=> outValid_o)
        else $error("pipeStage valid dropped without a transfer");

    holdData: assert property (@(posedge rvvi) disable iff (!arstN_i)
        outValid_o && !outReady_i |=> $stable(outData_o))
        else $error("pipeStage payload changed while stalled");

endmodule

// ==== rvfiDecode.sv ====
/*
 * Decode stage
 * Expands the RVFI destination write ports into a GPR
 * writeback mask and data array, then registers the record
 */
`timescale 1ns/1ps

module rvfiDecode (
    input  logic                     rvvi,
    input  logic                     arstN_i,
    input  logic                     rvfiValid_i,
    input  rvviTracePkg::rvfiRecordT rvfiRecord_i,
    output logic                     rvfiReady_o,
    output logic                     decValid_o,
    output rvviTracePkg::decodedT    decoded_o,
    input  logic                     decReady_i
);

    rvviTracePkg::decodedT decNext;

    ////////////////////
    // GPR expansion
    ////////////////////
    always_comb begin
        decNext.info    = rvfiRecord_i.info;
        decNext.csr     = rvfiRecord_i.csr;
        decNext.gprMask = '0;
        decNext.gprData = '0;
        // Later port wins when both name the same register
        for (int p = 0; p < rvviTracePkg::NUM_RD_PORTS; p++) begin
            // x0 is never written
            if (rvfiRecord_i.rd[p].addr != '0) begin
                decNext.gprMask[rvfiRecord_i.rd[p].addr] = 1'b1;
                decNext.gprData[rvfiRecord_i.rd[p].addr] = rvfiRecord_i.rd[p].data;
            end
        end
    end

    // Decode register
    pipeStage #(
        .payloadT (rvviTracePkg::decodedT)
    ) decStage (
        .rvvi       (rvvi),
        .arstN_i    (arstN_i),
        .inValid_i  (rvfiValid_i),
        .inData_i   (decNext),
        .inReady_o  (rvfiReady_o),
        .outValid_o (decValid_o),
        .outData_o  (decoded_o),
        .outReady_i (decReady_i)
    );

endmodule

// ==== csrMerge.sv ====
/*
 * Execute stage, combinational CSR merge
 * Value is wdata under wmask, rdata elsewhere; a changed
 * flag is raised against the last value handed on
 */
`timescale 1ns/1ps

module csrMerge (
    input  logic                     rvvi,
    input  logic                     arstN_i,
    input  logic                     decValid_i,
    input  rvviTracePkg::decodedT    decoded_i,
    output logic                     decReady_o,
    output logic                     resValid_o,
    output rvviTracePkg::rvviRecordT resRecord_o,
    input  logic                     resReady_i
);

    logic [rvviTracePkg::NUM_CSR-1:0][rvviTracePkg::XLEN-1:0] csrMerged;
    logic [rvviTracePkg::NUM_CSR-1:0][rvviTracePkg::XLEN-1:0] csrShadow;
    logic [rvviTracePkg::NUM_CSR-1:0]                         csrChanged;
    logic                                                     handoff;

    // Pure pass of the handshake, no storage here
    assign decReady_o = resReady_i;
    assign resValid_o = decValid_i;
    assign handoff    = decValid_i && resReady_i;

    ////////////////////
    // Merge per slot
    ////////////////////
    always_comb begin
        for (int i = 0; i < rvviTracePkg::NUM_CSR; i++) begin
            csrMerged[i] = (decoded_i.csr[i].wdata & decoded_i.csr[i].wmask)
                         | (decoded_i.csr[i].rdata & ~decoded_i.csr[i].wmask);
            csrChanged[i] = csrMerged[i] != csrShadow[i];
        end
    end

    always_comb begin
        resRecord_o.info       = decoded_i.info;
        resRecord_o.gprMask    = decoded_i.gprMask;
        resRecord_o.gprData    = decoded_i.gprData;
        resRecord_o.csrValue   = csrMerged;
        resRecord_o.csrChanged = csrChanged;
    end

    // Shadows follow what moves into the result stage
    always_ff @(posedge rvvi or negedge arstN_i) begin
        if (!arstN_i) begin
            csrShadow <= '0;
        end else if (handoff) begin
            csrShadow <= csrMerged;
        end
    end

    shadowOnHandoff: assert property (@(posedge rvvi) disable iff (!arstN_i)
        !$stable(csrShadow) |-> $past(decValid_i && decReady_o))
        else $error("csrMerge shadow moved without a decode handoff");

endmodule

// ==== traceResult.sv ====
/*
 * Result stage
 * Holds the finished RVVI record in the output register
 */
`timescale 1ns/1ps

module traceResult (
    input  logic                     rvvi,
    input  logic                     arstN_i,
    input  logic                     resValid_i,
    input  rvviTracePkg::rvviRecordT resRecord_i,
    output logic                     resReady_o,
    output logic                     traceValid_o,
    output rvviTracePkg::rvviRecordT trace_o,
    input  logic                     traceReady_i
);

    logic        seenFirst;
    logic [63:0] lastOrder;

    pipeStage #(
        .payloadT (rvviTracePkg::rvviRecordT)
    ) resStage (
        .rvvi       (rvvi),
        .arstN_i    (arstN_i),
        .inValid_i  (resValid_i),
        .inData_i   (resRecord_i),
        .inReady_o  (resReady_o),
        .outValid_o (traceValid_o),
        .outData_o  (trace_o),
        .outReady_i (traceReady_i)
    );

    ////////////////////
    // Retirement order
    ////////////////////
    always_ff @(posedge rvvi or negedge arstN_i) begin
        if (!arstN_i) begin
            seenFirst <= 1'b0;
            lastOrder <= '0;
        end else if (traceValid_o && traceReady_i) begin
            seenFirst <= 1'b1;
            lastOrder <= trace_o.info.order;
        end
    end

    orderStep: assert property (@(posedge rvvi) disable iff (!arstN_i)
        traceValid_o && traceReady_i && seenFirst
            |-> trace_o.info.order == lastOrder + 64'd1)
        else $error("traceResult order did not step by one");

endmodule

// ==== irqNetMonitor.sv ====
/*
 * Interrupt net monitor
 * Watches the masked irq lines and keeps one pending
 * event that gathers further changes until it is taken
 */
`timescale 1ns/1ps

module irqNetMonitor (
    input  logic                                 rvvi,
    input  logic                                 arstN_i,
    input  logic [rvviTracePkg::IRQ_W-1:0]       irq_i,
    output logic                                 netValid_o,
    output rvviTracePkg::netEventT               netEvent_o,
    input  logic                                 netReady_i
);

    logic [rvviTracePkg::IRQ_W-1:0] irqMasked;
    logic [rvviTracePkg::IRQ_W-1:0] irqPrev;
    logic [rvviTracePkg::IRQ_W-1:0] irqDelta;
    logic                           pending;
    logic                           take;
    rvviTracePkg::netEventT         eventQ;

    assign irqMasked  = irq_i & rvviTracePkg::IRQ_WATCH_MASK;
    assign irqDelta   = irqMasked ^ irqPrev;
    assign take       = pending && netReady_i;
    assign netValid_o = pending;
    assign netEvent_o = eventQ;

    always_ff @(posedge rvvi or negedge arstN_i) begin
        if (!arstN_i) begin
            irqPrev <= '0;
            pending <= 1'b0;
        end else begin
            irqPrev <= irqMasked;
            if (irqDelta != '0) begin
                pending <= 1'b1;
            end else if (take) begin
                pending <= 1'b0;
            end
        end
    end

    ////////////////////
    // Event coalescing
    ////////////////////
    always_ff @(posedge rvvi) begin
        if (irqDelta != '0) begin
            eventQ.level <= irqMasked;
            // Merge into an event still waiting, else start fresh
            if (pending && !take) begin
                eventQ.changed <= eventQ.changed | irqDelta;
            end else begin
                eventQ.changed <= irqDelta;
            end
        end
    end

endmodule

// ==== rvfiToRvvi.sv ====
/*
 * RVFI to RVVI trace converter top level
 * Decode, CSR merge and result stages plus the IRQ monitor
 */
`timescale 1ns/1ps

module rvfiToRvvi (
    input  logic                           rvvi,
    input  logic                           arstN_i,
    input  logic                           rvfiValid_i,
    input  rvviTracePkg::rvfiRecordT       rvfiRecord_i,
    output logic                           rvfiReady_o,
    output logic                           traceValid_o,
    output rvviTracePkg::rvviRecordT       trace_o,
    input  logic                           traceReady_i,
    input  logic [rvviTracePkg::IRQ_W-1:0] irq_i,
    output logic                           netValid_o,
    output rvviTracePkg::netEventT         netEvent_o,
    input  logic                           netReady_i
);

    logic                     decValid;
    logic                     decReady;
    rvviTracePkg::decodedT    decoded;
    logic                     resValid;
    logic                     resReady;
    rvviTracePkg::rvviRecordT resRecord;

    ////////////////////
    // Trace path
    ////////////////////
    rvfiDecode decodeU (
        .rvvi         (rvvi),
        .arstN_i      (arstN_i),
        .rvfiValid_i  (rvfiValid_i),
        .rvfiRecord_i (rvfiRecord_i),
        .rvfiReady_o  (rvfiReady_o),
        .decValid_o   (decValid),
        .decoded_o    (decoded),
        .decReady_i   (decReady)
    );

    csrMerge mergeU (
        .rvvi        (rvvi),
        .arstN_i     (arstN_i),
        .decValid_i  (decValid),
        .decoded_i   (decoded),
        .decReady_o  (decReady),
        .resValid_o  (resValid),
        .resRecord_o (resRecord),
        .resReady_i  (resReady)
    );

    traceResult resultU (
        .rvvi         (rvvi),
        .arstN_i      (arstN_i),
        .resValid_i   (resValid),
        .resRecord_i  (resRecord),
        .resReady_o   (resReady),
        .traceValid_o (traceValid_o),
        .trace_o      (trace_o),
        .traceReady_i (traceReady_i)
    );

    // Interrupt nets, independent of the trace path
    irqNetMonitor irqMonU (
        .rvvi       (rvvi),
        .arstN_i    (arstN_i),
        .irq_i      (irq_i),
        .netValid_o (netValid_o),
        .netEvent_o (netEvent_o),
        .netReady_i (netReady_i)
    );

endmodule

// ==== tbRvfiToRvvi.sv ====
/*
 * Testbench for the RVFI to RVVI trace converter
 * Applies a record table with random back-pressure, checks every
 * emitted trace record and every interrupt net event against models
 */
`timescale 1ns/1ps

module tbRvfiToRvvi;

    localparam int NUM_ROWS       = 16;
    localparam int TIMEOUT_CYCLES = NUM_ROWS * 8 + 200;
    // Software, timer, external and the local lines 16..31
    localparam logic [31:0] WATCHED = 32'hFFFF_0000 | (32'd1 << 3) | (32'd1 << 7)
                                    | (32'd1 << 11);

    typedef struct packed {
        logic [4:0]  rd0Addr;
        logic [4:0]  rd1Addr;
        logic [31:0] expMask;
        logic [5:0]  csrTouch;
        logic [31:0] csrSeed;
        logic [31:0] irq;
    } stimRowT;

    logic                     rvvi;
    logic                     arstN_i;
    logic                     rvfiValid_i;
    rvviTracePkg::rvfiRecordT rvfiRecord_i;
    logic                     rvfiReady_o;
    logic                     traceValid_o;
    rvviTracePkg::rvviRecordT trace_o;
    logic                     traceReady_i;
    logic [31:0]              irq_i;
    logic                     netValid_o;
    rvviTracePkg::netEventT   netEvent_o;
    logic                     netReady_i;

    stimRowT                  stimTable [NUM_ROWS];
    rvviTracePkg::rvviRecordT expQ [$];
    logic [rvviTracePkg::NUM_CSR-1:0][31:0] modelShadow;
    logic                     modelPending;
    rvviTracePkg::netEventT   modelEvent;
    logic [31:0]              modelPrev;
    logic [31:0]              lcgState = 32'd98416;
    logic                     holding;
    int                       idx;
    int                       warmLeft;
    int                       tailLeft;
    int                       cycleCount = 0;

    rvfiToRvvi uut (
        .rvvi         (rvvi),
        .arstN_i      (arstN_i),
        .rvfiValid_i  (rvfiValid_i),
        .rvfiRecord_i (rvfiRecord_i),
        .rvfiReady_o  (rvfiReady_o),
        .traceValid_o (traceValid_o),
        .trace_o      (trace_o),
        .traceReady_i (traceReady_i),
        .irq_i        (irq_i),
        .netValid_o   (netValid_o),
        .netEvent_o   (netEvent_o),
        .netReady_i   (netReady_i)
    );

    always #4 rvvi = ~rvvi;

    always @(posedge rvvi) begin
        cycleCount = cycleCount + 1;
        if (cycleCount >= TIMEOUT_CYCLES) begin
            abortRun($sformatf("Timeout after %0d cycles, the run did not drain", cycleCount));
        end
    end

    ////////////////////
    // Helpers
    ////////////////////
    task automatic abortRun(string why);
        $display("%s", why);
        $display("SIMULATION FAILED");
        $fatal(1, "Run stopped on the first failure");
    endtask

    task automatic compareField(string name, logic [63:0] expVal, logic [63:0] gotVal);
        if (gotVal !== expVal) begin
            abortRun($sformatf("** Error at time %0t: %s expected %h, got %h",
                               $time, name, expVal, gotVal));
        end
    endtask

    function automatic logic [31:0] nextRand();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    task automatic setRow(int i, logic [4:0] a0, logic [4:0] a1, logic [31:0] mask,
                          logic [5:0] touch, logic [31:0] seed, logic [31:0] irq);
        stimTable[i] = '{a0, a1, mask, touch, seed, irq};
    endtask

    // Ports, expected GPR mask, touched CSR slots, CSR seed, irq level
    task automatic fillTable();
        setRow(0,  5'd1,  5'd0,  32'h0000_0002, 6'h00, 32'h0000_0000, 32'h0000_0000);
        setRow(1,  5'd5,  5'd6,  32'h0000_0060, 6'h3F, 32'h1234_5678, 32'h0000_0008);
        setRow(2,  5'd0,  5'd0,  32'h0000_0000, 6'h00, 32'h0000_0000, 32'h0000_0008);
        setRow(3,  5'd0,  5'd9,  32'h0000_0200, 6'h05, 32'hDEAD_BEEF, 32'h0000_0088);
        setRow(4,  5'd12, 5'd12, 32'h0000_1000, 6'h3F, 32'h1234_5678, 32'h0000_0887);
        setRow(5,  5'd31, 5'd30, 32'hC000_0000, 6'h20, 32'hA5A5_0F0F, 32'h0000_0887);
        setRow(6,  5'd7,  5'd3,  32'h0000_0088, 6'h1F, 32'h0000_FFFF, 32'h0001_0887);
        setRow(7,  5'd0,  5'd31, 32'h8000_0000, 6'h00, 32'h0000_0000, 32'h0001_0007);
        setRow(8,  5'd2,  5'd2,  32'h0000_0004, 6'h2A, 32'h8000_0001, 32'h0000_0007);
        setRow(9,  5'd15, 5'd16, 32'h0001_8000, 6'h15, 32'h7654_3210, 32'h0000_4007);
        setRow(10, 5'd20, 5'd0,  32'h0010_0000, 6'h3F, 32'h0000_0000, 32'h8000_0000);
        setRow(11, 5'd8,  5'd9,  32'h0000_0300, 6'h01, 32'h0000_0001, 32'h8000_0800);
        setRow(12, 5'd0,  5'd0,  32'h0000_0000, 6'h00, 32'h0000_0000, 32'h0000_0800);
        setRow(13, 5'd27, 5'd4,  32'h0800_0010, 6'h3C, 32'h3C1E_77A2, 32'h0000_0803);
        setRow(14, 5'd11, 5'd11, 32'h0000_0800, 6'h12, 32'h5555_AAAA, 32'hFFFF_0000);
        setRow(15, 5'd1,  5'd2,  32'h0000_0006, 6'h3F, 32'hFFFF_FFFF, 32'h0000_0000);
    endtask

    ////////////////////
    // Stimulus and models
    ////////////////////
    function automatic rvviTracePkg::rvfiRecordT buildRecord(int row);
        rvviTracePkg::rvfiRecordT rec;
        logic [31:0]              seed;
        seed           = stimTable[row].csrSeed;
        rec.info.order = 64'h1000 + 64'(row);
        rec.info.pc    = 32'h8000_0000 + 32'(row * 4);
        rec.info.insn  = nextRand();
        rec.info.trap  = (row == 7);
        rec.info.intr  = (row == 9);
        rec.info.mode  = 2'(row);
        rec.info.ixl   = 2'd1;
        rec.rd[0].addr = stimTable[row].rd0Addr;
        rec.rd[0].data = nextRand();
        rec.rd[1].addr = stimTable[row].rd1Addr;
        rec.rd[1].data = nextRand();
        for (int s = 0; s < rvviTracePkg::NUM_CSR; s++) begin
            if (stimTable[row].csrTouch[s]) begin
                rec.csr[s].rdata = seed + 32'(s) * 32'h0101_0101;
                rec.csr[s].wdata = ~seed ^ (32'(s) << 4);
                rec.csr[s].wmask = {seed[7:0], seed[31:8]} ^ (32'h0000_00FF << (4 * s));
            end else begin
                // Plain read of the current value with the write data masked off
                rec.csr[s].rdata = modelShadow[s];
                rec.csr[s].wdata = nextRand();
                rec.csr[s].wmask = '0;
            end
        end
        return rec;
    endfunction

    function automatic rvviTracePkg::rvviRecordT expectRecord(rvviTracePkg::rvfiRecordT rec,
                                                              int row);
        rvviTracePkg::rvviRecordT expRec;
        logic [31:0]              merged;
        expRec         = '0;
        expRec.info    = rec.info;
        expRec.gprMask = stimTable[row].expMask;
        // Port 1 goes last and wins on a shared register
        for (int p = 0; p < 2; p++) begin
            if (rec.rd[p].addr != 5'd0) begin
                expRec.gprData[rec.rd[p].addr] = rec.rd[p].data;
            end
        end
        for (int s = 0; s < rvviTracePkg::NUM_CSR; s++) begin
            // Each bit picks write data where its mask bit is set
            for (int b = 0; b < 32; b++) begin
                merged[b] = rec.csr[s].wmask[b] ? rec.csr[s].wdata[b] : rec.csr[s].rdata[b];
            end
            expRec.csrValue[s]   = merged;
            expRec.csrChanged[s] = merged != modelShadow[s];
            modelShadow[s]       = merged;
        end
        return expRec;
    endfunction

    ////////////////////
    // Checks
    ////////////////////
    task automatic checkTrace(rvviTracePkg::rvviRecordT got, rvviTracePkg::rvviRecordT expRec);
        compareField("trace_o.info.order", expRec.info.order, got.info.order);
        compareField("trace_o.info.pc", 64'(expRec.info.pc), 64'(got.info.pc));
        compareField("trace_o.info.insn", 64'(expRec.info.insn), 64'(got.info.insn));
        compareField("trace_o.info.trap", 64'(expRec.info.trap), 64'(got.info.trap));
        compareField("trace_o.info.intr", 64'(expRec.info.intr), 64'(got.info.intr));
        compareField("trace_o.info.mode", 64'(expRec.info.mode), 64'(got.info.mode));
        compareField("trace_o.info.ixl", 64'(expRec.info.ixl), 64'(got.info.ixl));
        compareField("trace_o.gprMask", 64'(expRec.gprMask), 64'(got.gprMask));
        for (int r = 0; r < rvviTracePkg::NUM_GPR; r++) begin
            if (expRec.gprMask[r]) begin
                compareField($sformatf("trace_o.gprData[%0d]", r),
                             64'(expRec.gprData[r]), 64'(got.gprData[r]));
            end
        end
        for (int s = 0; s < rvviTracePkg::NUM_CSR; s++) begin
            compareField($sformatf("trace_o.csrValue[%0d]", s),
                         64'(expRec.csrValue[s]), 64'(got.csrValue[s]));
        end
        compareField("trace_o.csrChanged", 64'(expRec.csrChanged), 64'(got.csrChanged));
    endtask

    task automatic checkNet(rvviTracePkg::netEventT got, rvviTracePkg::netEventT expEvent);
        compareField("netEvent_o.level", 64'(expEvent.level), 64'(got.level));
        compareField("netEvent_o.changed", 64'(expEvent.changed), 64'(got.changed));
    endtask

    ////////////////////
    // Per-cycle work
    ////////////////////
    // Inputs change 1 ns after the edge
    task automatic driveCycle();
        logic [31:0] r;
        int          irqRow;
        @(posedge rvvi);
        #1;
        if (!holding) begin
            rvfiValid_i = 1'b0;
            r = nextRand();
            if (warmLeft > 0) begin
                warmLeft = warmLeft - 1;
            end else if (idx < NUM_ROWS && r[31:24] >= 8'd64) begin
                rvfiRecord_i = buildRecord(idx);
                rvfiValid_i  = 1'b1;
                holding      = 1'b1;
            end
        end
        r = nextRand();
        traceReady_i = r[31:24] >= 8'd77;
        r = nextRand();
        netReady_i = r[31:24] >= 8'd77;
        irqRow = (idx < NUM_ROWS) ? idx : NUM_ROWS - 1;
        irq_i = stimTable[irqRow].irq;
    endtask

    // Sampled mid-cycle once every handshake signal has settled
    task automatic observeCycle();
        rvviTracePkg::rvviRecordT expRec;
        logic [31:0]              masked;
        logic [31:0]              delta;
        logic                     take;
        logic                     expReady;
        // Both stages are full only with two records in flight
        expReady = (expQ.size() == 2) ? traceReady_i : 1'b1;
        compareField("rvfiReady_o", 64'(expReady), 64'(rvfiReady_o));
        if (traceValid_o && expQ.size() == 0) begin
            abortRun("traceValid_o went high with no record in flight");
        end else if (traceValid_o && traceReady_i) begin
            expRec = expQ.pop_front();
            checkTrace(trace_o, expRec);
        end
        if (rvfiValid_i && rvfiReady_o) begin
            expQ.push_back(expectRecord(rvfiRecord_i, idx));
            idx     = idx + 1;
            holding = 1'b0;
        end
        // Net model keeps one pending event that gathers changes
        compareField("netValid_o", 64'(modelPending), 64'(netValid_o));
        take = modelPending && netReady_i;
        if (take) begin
            checkNet(netEvent_o, modelEvent);
        end
        masked = irq_i & WATCHED;
        delta  = masked ^ modelPrev;
        if (delta != '0) begin
            modelEvent.changed = (modelPending && !take) ? (modelEvent.changed | delta) : delta;
            modelEvent.level   = masked;
            modelPending       = 1'b1;
        end else if (take) begin
            modelPending = 1'b0;
        end
        modelPrev = masked;
    endtask

    initial begin
        rvvi         = 1'b0;
        arstN_i      = 1'b0;
        rvfiValid_i  = 1'b0;
        rvfiRecord_i = '0;
        traceReady_i = 1'b0;
        irq_i        = '0;
        netReady_i   = 1'b0;
        modelShadow  = '0;
        modelPending = 1'b0;
        modelEvent   = '0;
        modelPrev    = '0;
        holding      = 1'b0;
        idx          = 0;
        warmLeft     = 4;
        tailLeft     = 6;
        fillTable();
        repeat (10) @(posedge rvvi);
        #1;
        arstN_i = 1'b1;
        // A few quiet cycles after the last record catch stray outputs
        while (tailLeft > 0) begin
            driveCycle();
            @(negedge rvvi);
            observeCycle();
            if (idx == NUM_ROWS && !holding && expQ.size() == 0 && !modelPending) begin
                tailLeft = tailLeft - 1;
            end
        end
        if (expQ.size() != 0 || modelPending) begin
            abortRun("Run ended with trace records or net events still outstanding");
        end else begin
            $display("SIMULATION PASSED");
            $finish;
        end
    end

endmodule

// ==== all.f ====
rvviTracePkg.sv
pipeStage.sv
rvfiDecode.sv
csrMerge.sv
traceResult.sv
irqNetMonitor.sv
rvfiToRvvi.sv
tbRvfiToRvvi.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the trace converter testbench with Verilator.
# The exit status is the simulator's own: nonzero on any $fatal.

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert \
        --top-module tbRvfiToRvvi \
        -f all.f \
        -o simTb; then
    echo "Verilator build failed"
    exit 1
fi

if ! ./obj_dir/simTb; then
    echo "Simulation exited with a failing status"
    exit 1
fi

exit 0
